//--- verilog.f
design/vga_text_pkg.sv
design/vga_timing.sv
design/text_scan_fetch.sv
design/vram_arbiter.sv
design/video_ram.sv
design/apb_vram_port.sv
design/vga_text_top.sv
tb/tb_vga_text.sv

//--- Bender.yml
package:
  name: vga_text

sources:
  - files:
      - design/vga_text_pkg.sv
      - design/vga_timing.sv
      - design/text_scan_fetch.sv
      - design/vram_arbiter.sv
      - design/video_ram.sv
      - design/apb_vram_port.sv
      - design/vga_text_top.sv
  - target: test
    files:
      - tb/tb_vga_text.sv

//--- tb/tb_vga_text.sv
`default_nettype none
`timescale 1ns/1ps

module tb_vga_text
    import vga_text_pkg::*;
();

    localparam longint frame_ns = longint'(h_total) * v_total * 40;
    localparam longint setup_ns = longint'(cell_count + 96 * glyph_h + 2000) * 8 * 40;

    logic       clk_25M;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    logic       pready;
    apb_data_t  prdata;
    logic       pslverr;
    logic [2:0] video_red;
    logic [2:0] video_green;
    logic [1:0] video_blue;
    logic       video_hsync;
    logic       video_vsync;
    logic       video_de;

    // mirror of every byte written into the video ram
    byte_t  model [int];
    integer seed = 32'h83e5_d9e2;
    logic   exp_err;
    byte_t  exp_rdata;
    logic   pix_armed;

    // beam tracking from the video outputs
    logic hs_q;
    logic vs_q;
    logic de_q;
    logic hs_seen;
    int   hs_gap;
    int   hs_width;
    int   vs_width;
    int   px_x;
    int   px_y;
    int   vs_rises;

    vga_text_top i_dut (
        .clk_25M     (clk_25M),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .video_red   (video_red),
        .video_green (video_green),
        .video_blue  (video_blue),
        .video_hsync (video_hsync),
        .video_vsync (video_vsync),
        .video_de    (video_de)
    );

    initial begin
        clk_25M = 1'b0;
        forever #20 clk_25M = ~clk_25M;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial begin
        #(3 * frame_ns + setup_ns);
        $display("watchdog expired before the test sequence completed");
        abort_run();
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic is_mapped(input int addr);
        return (addr >= cell_base && addr < cell_base + cell_count)
            || (addr >= glyph_base && addr < vram_depth);
    endfunction

    function automatic int random_mapped_addr();
        if (rand_below(2) == 0) begin
            return cell_base + rand_below(cell_count);
        end
        return glyph_base + rand_below(vram_depth - glyph_base);
    endfunction

    // expected pixel from the model, bit 7 is the leftmost pixel
    function automatic logic pixel_at(input int x, input int y);
        int    code;
        byte_t bits;
        code = model[cell_base + (y / glyph_h) * cols + x / glyph_w];
        if (code < first_code || code > last_code) begin
            return 1'b0;
        end
        bits = model[glyph_base + (code - first_code) * glyph_h + y % glyph_h];
        return bits[glyph_w - 1 - x % glyph_w];
    endfunction

    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            de_q     <= 1'b0;
            hs_seen  <= 1'b0;
            hs_gap   <= 0;
            hs_width <= 0;
            vs_width <= 0;
            px_x     <= 0;
            px_y     <= 0;
            vs_rises <= 0;
        end else begin
            hs_q <= video_hsync;
            vs_q <= video_vsync;
            de_q <= video_de;
            if (video_hsync && !hs_q) begin
                hs_gap  <= 1;
                hs_seen <= 1'b1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
            hs_width <= video_hsync ? hs_width + 1 : 0;
            vs_width <= video_vsync ? vs_width + 1 : 0;
            px_x     <= video_de ? px_x + 1 : 0;
            // y restarts during vsync and steps at each falling de
            if (video_vsync) begin
                px_y <= 0;
            end else if (de_q && !video_de) begin
                px_y <= px_y + 1;
            end
            if (video_vsync && !vs_q) begin
                vs_rises <= vs_rises + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk_25M)
        $past(rst) |-> !pready && !pslverr && !video_hsync && !video_vsync
            && !video_de && video_red == '0 && video_green == '0 && video_blue == '0)
    else begin
        $display("CHECK FAILED at %0t: outputs in reset expected all 0, got pready=%b",
                 $time, $sampled(pready),
                 " pslverr=%b hsync=%b vsync=%b de=%b rgb=%h/%h/%h",
                 $sampled(pslverr), $sampled(video_hsync), $sampled(video_vsync),
                 $sampled(video_de), $sampled(video_red), $sampled(video_green),
                 $sampled(video_blue));
        abort_run();
    end

    hsync_period: assert property (@(posedge clk_25M) disable iff (rst)
        $rose(video_hsync) && hs_seen |-> hs_gap == h_total)
    else begin
        $display("CHECK FAILED at %0t: video_hsync period expected %0d, got %0d",
                 $time, h_total, $sampled(hs_gap));
        abort_run();
    end

    hsync_width: assert property (@(posedge clk_25M) disable iff (rst)
        $fell(video_hsync) |-> hs_width == h_sync_end - h_sync_start)
    else begin
        $display("CHECK FAILED at %0t: video_hsync width expected %0d, got %0d",
                 $time, h_sync_end - h_sync_start, $sampled(hs_width));
        abort_run();
    end

    de_per_line: assert property (@(posedge clk_25M) disable iff (rst)
        $fell(video_de) |-> px_x == h_visible)
    else begin
        $display("CHECK FAILED at %0t: video_de clocks per line expected %0d, got %0d",
                 $time, h_visible, $sampled(px_x));
        abort_run();
    end

    de_per_frame: assert property (@(posedge clk_25M) disable iff (rst)
        $rose(video_vsync) |-> px_y == v_visible)
    else begin
        $display("CHECK FAILED at %0t: video_de lines per frame expected %0d, got %0d",
                 $time, v_visible, $sampled(px_y));
        abort_run();
    end

    vsync_width: assert property (@(posedge clk_25M) disable iff (rst)
        $fell(video_vsync) |-> vs_width == (v_sync_end - v_sync_start) * h_total)
    else begin
        $display("CHECK FAILED at %0t: video_vsync clocks expected %0d, got %0d",
                 $time, (v_sync_end - v_sync_start) * h_total, $sampled(vs_width));
        abort_run();
    end

    apb_error_flag: assert property (@(posedge clk_25M) disable iff (rst)
        psel && penable && pready |-> pslverr == exp_err)
    else begin
        $display("CHECK FAILED at %0t: pslverr at paddr %0d expected %b, got %b",
                 $time, $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
        abort_run();
    end

    apb_read_data: assert property (@(posedge clk_25M) disable iff (rst)
        psel && penable && pready && !pwrite |-> prdata == apb_data_t'(exp_rdata))
    else begin
        $display("CHECK FAILED at %0t: prdata at paddr %0d expected %h, got %h",
                 $time, $sampled(paddr), $sampled(exp_rdata), $sampled(prdata));
        abort_run();
    end

    pixel_colour: assert property (@(posedge clk_25M) disable iff (rst)
        pix_armed && video_de |-> video_red == {3{pixel_at(px_x, px_y)}}
            && video_green == {3{pixel_at(px_x, px_y)}}
            && video_blue == {2{pixel_at(px_x, px_y)}})
    else begin
        $display("CHECK FAILED at %0t: video rgb at x=%0d y=%0d expected %b, got %h/%h/%h",
                 $time, $sampled(px_x), $sampled(px_y),
                 pixel_at($sampled(px_x), $sampled(px_y)),
                 $sampled(video_red), $sampled(video_green), $sampled(video_blue));
        abort_run();
    end

    // one apb transfer, the response is checked by the apb assertions
    task automatic apb_access(input logic write, input int addr, input byte_t wdata);
        int   waits;
        logic mapped;
        mapped = is_mapped(addr);
        @(posedge clk_25M);
        #1;
        exp_err   = !mapped;
        exp_rdata = (mapped && !write) ? model[addr] : 8'h00;
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = write;
        paddr     = apb_addr_t'(addr);
        pwdata    = $random(seed);
        pwdata[7:0] = wdata;
        @(posedge clk_25M);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(posedge clk_25M);
        while (!pready && waits < 16) begin
            waits++;
            @(posedge clk_25M);
        end
        if (!pready) begin
            $display("APB access to address %0d got no pready within 16 cycles", addr);
            abort_run();
        end else begin
            if (write && mapped) begin
                model[addr] = wdata;
            end
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic load_font();
        for (int a = glyph_base; a < vram_depth; a++) begin
            apb_access(1'b1, a, byte_t'($random(seed)));
        end
    endtask

    // mostly printable codes, a few outside the glyph range
    task automatic load_text();
        for (int i = 0; i < cell_count; i++) begin
            apb_access(1'b1, cell_base + i, byte_t'(i % 100 + 30));
        end
    endtask

    task automatic write_read_random(input int n);
        int addr;
        repeat (n) begin
            addr = random_mapped_addr();
            apb_access(1'b1, addr, byte_t'($random(seed)));
            apb_access(1'b0, addr, 8'h00);
        end
    endtask

    task automatic probe_unmapped(input int n);
        int addr;
        repeat (n) begin
            if (rand_below(2) == 0) begin
                addr = cell_base + cell_count + rand_below(glyph_base - cell_count);
            end else begin
                addr = vram_depth + rand_below(65536 - vram_depth);
            end
            apb_access(1'b1, addr, byte_t'($random(seed)));
            apb_access(1'b0, addr, 8'h00);
        end
    endtask

    task automatic read_all_mapped();
        for (int a = 0; a < vram_depth; a++) begin
            if (is_mapped(a)) begin
                apb_access(1'b0, a, 8'h00);
            end
        end
    endtask

    // rewrites keep the model value so the picture stays predictable
    task automatic video_traffic(input int n);
        int addr;
        int pick;
        @(posedge clk_25M);
        while (!video_de) begin
            @(posedge clk_25M);
        end
        repeat (n) begin
            pick = rand_below(8);
            if (pick == 0) begin
                addr = cell_base + cell_count + rand_below(glyph_base - cell_count);
                apb_access(1'b1, addr, 8'hff);
            end else begin
                addr = random_mapped_addr();
                if (pick < 4) begin
                    apb_access(1'b1, addr, model[addr]);
                end else begin
                    apb_access(1'b0, addr, 8'h00);
                end
            end
        end
    endtask

    initial begin
        int frames;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        exp_err   = 1'b0;
        exp_rdata = 8'h00;
        pix_armed = 1'b0;
        repeat (3) @(posedge clk_25M);
        #1;
        rst = 1'b0;

        load_font();
        load_text();
        write_read_random(40);
        probe_unmapped(40);
        read_all_mapped();

        // start pixel checks at a frame boundary
        frames = vs_rises;
        wait (vs_rises > frames);
        pix_armed = 1'b1;
        frames    = vs_rises;
        repeat (4) begin
            repeat (100 * h_total) @(posedge clk_25M);
            video_traffic(150);
        end
        wait (vs_rises >= frames + 2);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/vga_text_top.sv
`default_nettype none
`timescale 1ns/1ps

module vga_text_top
    import vga_text_pkg::*;
(
    input  logic       clk_25M,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output logic       pready,
    output apb_data_t  prdata,
    output logic       pslverr,
    output logic [2:0] video_red,
    output logic [2:0] video_green,
    output logic [1:0] video_blue,
    output logic       video_hsync,
    output logic       video_vsync,
    output logic       video_de
);

    coord_t     hcount;
    coord_t     vcount;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       de_raw;
    logic       pixel;
    logic       scan_req;
    vram_addr_t scan_addr;
    logic       apb_req;
    vram_addr_t apb_addr;
    logic       apb_we;
    byte_t      apb_wdata;
    logic       apb_gnt;
    logic       ram_en;
    logic       ram_we;
    vram_addr_t ram_addr;
    byte_t      ram_wdata;
    byte_t      rdata;

    vga_timing u_timing (
        .clk_25M (clk_25M),
        .rst     (rst),
        .hcount  (hcount),
        .vcount  (vcount),
        .hsync   (hsync_raw),
        .vsync   (vsync_raw),
        .de      (de_raw)
    );

    text_scan_fetch u_fetch (
        .clk_25M   (clk_25M),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync_in  (hsync_raw),
        .vsync_in  (vsync_raw),
        .de_in     (de_raw),
        .scan_req  (scan_req),
        .scan_addr (scan_addr),
        .rdata     (rdata),
        .pixel     (pixel),
        .hsync     (video_hsync),
        .vsync     (video_vsync),
        .de        (video_de)
    );

    vram_arbiter u_arbiter (
        .clk_25M   (clk_25M),
        .rst       (rst),
        .scan_req  (scan_req),
        .scan_addr (scan_addr),
        .apb_req   (apb_req),
        .apb_addr  (apb_addr),
        .apb_we    (apb_we),
        .apb_wdata (apb_wdata),
        .apb_gnt   (apb_gnt),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    video_ram u_ram (
        .clk_25M (clk_25M),
        .en      (ram_en),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (rdata)
    );

    apb_vram_port u_apb (
        .clk_25M   (clk_25M),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .apb_req   (apb_req),
        .apb_addr  (apb_addr),
        .apb_we    (apb_we),
        .apb_wdata (apb_wdata),
        .apb_gnt   (apb_gnt),
        .rdata     (rdata)
    );

    // monochrome, same bit on every colour channel
    assign video_red   = {3{pixel}};
    assign video_green = {3{pixel}};
    assign video_blue  = {2{pixel}};

endmodule

`default_nettype wire

//--- design/apb_vram_port.sv
`default_nettype none
`timescale 1ns/1ps

module apb_vram_port
    import vga_text_pkg::*;
(
    input  logic       clk_25M,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output logic       pready,
    output apb_data_t  prdata,
    output logic       pslverr,
    output logic       apb_req,
    output vram_addr_t apb_addr,
    output logic       apb_we,
    output byte_t      apb_wdata,
    input  logic       apb_gnt,
    input  byte_t      rdata
);

    logic access;
    logic mapped;
    logic granted;

    assign access = psel & penable;

    // cell region or glyph region, the gap between them is unmapped
    assign mapped = (paddr >= apb_addr_t'(cell_base)
                     && paddr < apb_addr_t'(cell_base + cell_count))
                 || (paddr >= apb_addr_t'(glyph_base)
                     && paddr < apb_addr_t'(vram_depth));

    // request stays up until the arbiter grants it
    assign apb_req   = access & mapped & ~granted;
    assign apb_addr  = vram_addr_t'(paddr);
    assign apb_we    = pwrite;
    assign apb_wdata = pwdata[7:0];

    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            granted <= 1'b0;
        end else begin
            granted <= apb_gnt;
        end
    end

    // unmapped accesses finish at once with an error
    assign pslverr = access & ~mapped;
    assign pready  = granted | pslverr;

    // ram read data is valid in the cycle after the grant
    always_comb begin
        prdata = '0;
        if (granted && !pwrite) begin
            prdata = apb_data_t'(rdata);
        end
    end

endmodule

`default_nettype wire

//--- design/video_ram.sv
`default_nettype none
`timescale 1ns/1ps

module video_ram
    import vga_text_pkg::*;
(
    input  logic       clk_25M,
    input  logic       en,
    input  logic       we,
    input  vram_addr_t addr,
    input  byte_t      wdata,
    output byte_t      rdata
);

    byte_t mem [vram_depth];

    // read returns the old contents on a write
    always_ff @(posedge clk_25M) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- design/vram_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter
    import vga_text_pkg::*;
(
    input  logic       clk_25M,
    input  logic       rst,
    input  logic       scan_req,
    input  vram_addr_t scan_addr,
    input  logic       apb_req,
    input  vram_addr_t apb_addr,
    input  logic       apb_we,
    input  byte_t      apb_wdata,
    output logic       apb_gnt,
    output logic       ram_en,
    output logic       ram_we,
    output vram_addr_t ram_addr,
    output byte_t      ram_wdata
);

    // scan fetcher always wins, apb takes the leftover cycles
    always_comb begin
        apb_gnt   = 1'b0;
        ram_en    = 1'b0;
        ram_we    = 1'b0;
        ram_addr  = scan_addr;
        ram_wdata = apb_wdata;
        if (scan_req) begin
            ram_en = 1'b1;
        end else if (apb_req) begin
            apb_gnt  = 1'b1;
            ram_en   = 1'b1;
            ram_we   = apb_we;
            ram_addr = apb_addr;
        end
    end

endmodule

`default_nettype wire

//--- design/text_scan_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module text_scan_fetch
    import vga_text_pkg::*;
(
    input  logic       clk_25M,
    input  logic       rst,
    input  coord_t     hcount,
    input  coord_t     vcount,
    input  logic       hsync_in,
    input  logic       vsync_in,
    input  logic       de_in,
    output logic       scan_req,
    output vram_addr_t scan_addr,
    input  byte_t      rdata,
    output logic       pixel,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);

    logic [2:0] slot;
    coord_t     win;
    coord_t     next_col;
    coord_t     next_line;
    coord_t     fetch_line;
    coord_t     cell_row;
    logic [3:0] glyph_row;
    logic       fetch_valid;
    byte_t      code;
    byte_t      code_off;
    logic       code_ok;
    vram_addr_t cell_addr;
    vram_addr_t glyph_addr;
    byte_t      next_row;
    byte_t      shift;

    // position inside the 8-clock window and the window index
    assign slot = hcount[2:0];
    assign win  = hcount / coord_t'(glyph_w);

    assign next_line = (vcount == coord_t'(v_total - 1)) ? '0 : vcount + 1'b1;

    // last window of a line prefetches column 0 of the following line
    always_comb begin
        if (win == coord_t'(h_total / glyph_w - 1)) begin
            next_col   = '0;
            fetch_line = next_line;
        end else begin
            next_col   = win + 1'b1;
            fetch_line = vcount;
        end
    end

    assign cell_row    = fetch_line / coord_t'(glyph_h);
    assign glyph_row   = 4'(fetch_line % coord_t'(glyph_h));
    assign fetch_valid = (next_col < coord_t'(cols)) && (cell_row < coord_t'(rows));

    assign cell_addr = vram_addr_t'(cell_base)
                     + vram_addr_t'(cell_row) * vram_addr_t'(cols)
                     + vram_addr_t'(next_col);

    assign code_off   = code - byte_t'(first_code);
    assign glyph_addr = vram_addr_t'(glyph_base)
                      + vram_addr_t'(code_off) * vram_addr_t'(glyph_h)
                      + vram_addr_t'(glyph_row);

    // codes without a glyph show as blank
    assign code_ok = fetch_valid
                   && (code >= byte_t'(first_code))
                   && (code <= byte_t'(last_code));

    // slot 0 reads the cell, slot 2 reads the glyph row
    always_comb begin
        scan_req  = 1'b0;
        scan_addr = cell_addr;
        if (slot == 3'd0) begin
            if (fetch_valid) begin
                scan_req = 1'b1;
            end
        end else if (slot == 3'd2) begin
            scan_addr = glyph_addr;
            if (code_ok) begin
                scan_req = 1'b1;
            end
        end
    end

    // cell code arrives one cycle after the slot 0 read
    always_ff @(posedge clk_25M) begin
        if (slot == 3'd1) begin
            code <= rdata;
        end
    end

    // glyph row arrives in slot 3
    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            next_row <= '0;
        end else if (slot == 3'd3) begin
            if (code_ok) begin
                next_row <= rdata;
            end else begin
                next_row <= '0;
            end
        end
    end

    // msb first, loaded at the window boundary
    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            shift <= '0;
        end else if (slot == 3'd7) begin
            shift <= next_row;
        end else begin
            shift <= {shift[6:0], 1'b0};
        end
    end

    // pixel and syncs of the same counter value leave together
    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            pixel <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            pixel <= de_in & shift[7];
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= de_in;
        end
    end

endmodule

`default_nettype wire

//--- design/vga_timing.sv
`default_nettype none
`timescale 1ns/1ps

module vga_timing
    import vga_text_pkg::*;
(
    input  logic   clk_25M,
    input  logic   rst,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   de
);

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == coord_t'(h_total - 1));
    assign frame_end = (vcount == coord_t'(v_total - 1));

    // pixel counter within the line
    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            hcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // line counter, steps once per line
    always_ff @(posedge clk_25M or posedge rst) begin
        if (rst) begin
            vcount <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // sync pulses are active high
    assign hsync = (hcount >= coord_t'(h_sync_start)) && (hcount < coord_t'(h_sync_end));
    assign vsync = (vcount >= coord_t'(v_sync_start)) && (vcount < coord_t'(v_sync_end));
    assign de    = (hcount < coord_t'(h_visible)) && (vcount < coord_t'(v_visible));

endmodule

`default_nettype wire

//--- design/vga_text_pkg.sv
`default_nettype none

package vga_text_pkg;

    // horizontal timing in pixel clocks
    localparam int h_visible    = 640;
    localparam int h_sync_start = 656;
    localparam int h_sync_end   = 752;
    localparam int h_total      = 800;

    // vertical timing in lines
    localparam int v_visible    = 480;
    localparam int v_sync_start = 490;
    localparam int v_sync_end   = 492;
    localparam int v_total      = 525;

    // character grid
    localparam int cols    = 80;
    localparam int rows    = 30;
    localparam int glyph_w = 8;
    localparam int glyph_h = 16;

    // video ram map
    localparam int cell_base  = 0;
    localparam int cell_count = 2400;
    localparam int glyph_base = 2560;
    localparam int first_code = 32;
    localparam int last_code  = 127;
    localparam int vram_depth = 4096;

    typedef logic [11:0] vram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  coord_t;
    typedef logic [15:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire
